// ==== common/dct_pkg.sv ====
`default_nettype none

package dct_pkg;

    // sample and coefficient types along the pipeline
    typedef logic signed [8:0]  pix_t;
    typedef logic signed [12:0] row_t;
    typedef logic signed [14:0] coef_t;
    typedef logic        [2:0]  idx_t;
    typedef logic        [3:0]  shift_t;

    localparam int N_PT  = 8;
    localparam int ACC_W = 24;

    // 64 * c(k) * cos((2n+1)k*pi/16), rounded; indexed [k][n]
    localparam logic signed [7:0] DCT_COS [N_PT][N_PT] = '{
        '{ 45,  45,  45,  45,  45,  45,  45,  45},
        '{ 63,  53,  36,  12, -12, -36, -53, -63},
        '{ 59,  24, -24, -59, -59, -24,  24,  59},
        '{ 53, -12, -63, -36,  36,  63,  12, -53},
        '{ 45, -45, -45,  45,  45, -45, -45,  45},
        '{ 36, -63,  12,  53, -53, -12,  63, -36},
        '{ 24, -59,  59, -24, -24,  59, -59,  24},
        '{ 12, -36,  53, -63,  63, -53,  36, -12}
    };

    // register map
    localparam logic [1:0] REG_SHIFT_ROW = 2'd0;
    localparam logic [1:0] REG_SHIFT_COL = 2'd1;
    localparam logic [1:0] REG_BLOCKS    = 2'd2;

    localparam shift_t SHIFT_ROW_RST = 4'd5;
    localparam shift_t SHIFT_COL_RST = 4'd8;

endpackage

`default_nettype wire

// ==== verilog/dct_1d.sv ====
`default_nettype none

module dct_1d #(
    parameter type in_t  = dct_pkg::pix_t,
    parameter type out_t = dct_pkg::row_t
) (
    input  wire logic           clk,
    input  wire logic           resetn,

    input  wire in_t            d_i [dct_pkg::N_PT],
    input  wire dct_pkg::idx_t  d_cnt_i,
    input  wire logic           d_valid_i,
    output logic                d_hold_o,

    input  wire dct_pkg::shift_t shift_i,

    output out_t                q_o [dct_pkg::N_PT],
    output dct_pkg::idx_t       q_cnt_o,
    output logic                q_valid_o,
    input  wire logic           q_hold_i
);

    localparam int OUT_W = $bits(out_t);

    // clamp limits of out_t, sign-extended to the accumulator width
    localparam logic signed [dct_pkg::ACC_W-1:0] OUT_MAX =
        {{(dct_pkg::ACC_W - OUT_W + 1){1'b0}}, {(OUT_W - 1){1'b1}}};
    localparam logic signed [dct_pkg::ACC_W-1:0] OUT_MIN = ~OUT_MAX;

    localparam logic signed [dct_pkg::ACC_W-1:0] ONE =
        {{(dct_pkg::ACC_W - 1){1'b0}}, 1'b1};

    logic signed [dct_pkg::ACC_W-1:0] rnd;
    logic signed [dct_pkg::ACC_W-1:0] acc     [dct_pkg::N_PT];
    logic signed [dct_pkg::ACC_W-1:0] shifted [dct_pkg::N_PT];
    out_t                             sat     [dct_pkg::N_PT];
    logic                             accept;

    // half an LSB of the shift, zero when no shift
    always_comb begin
        rnd = (ONE << shift_i) >> 1;
    end

    always_comb begin
        for (int k = 0; k < dct_pkg::N_PT; k++) begin
            acc[k] = rnd;
            for (int n = 0; n < dct_pkg::N_PT; n++) begin
                acc[k] = acc[k] + dct_pkg::DCT_COS[k][n] * d_i[n];
            end
            shifted[k] = acc[k] >>> shift_i;
            if (shifted[k] > OUT_MAX) begin
                sat[k] = OUT_MAX[OUT_W-1:0];
            end else if (shifted[k] < OUT_MIN) begin
                sat[k] = OUT_MIN[OUT_W-1:0];
            end else begin
                sat[k] = shifted[k][OUT_W-1:0];
            end
        end
    end

    // stall passes straight through, the output reg only moves when not held
    always_comb begin
        d_hold_o = q_hold_i;
        accept   = d_valid_i & ~q_hold_i;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_valid_o <= 1'b0;
        end else if (!q_hold_i) begin
            q_valid_o <= d_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int k = 0; k < dct_pkg::N_PT; k++) begin
                q_o[k] <= sat[k];
            end
            q_cnt_o <= d_cnt_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dct_cfg_regs.sv ====
`default_nettype none

module dct_cfg_regs (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire logic            reg_we_i,
    input  wire logic [1:0]      reg_addr_i,
    input  wire logic [7:0]      reg_wdata_i,
    output logic      [7:0]      reg_rdata_o,

    input  wire logic            block_done_i,

    output dct_pkg::shift_t      shift_row_o,
    output dct_pkg::shift_t      shift_col_o
);

    logic [7:0] blocks;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            shift_row_o <= dct_pkg::SHIFT_ROW_RST;
            shift_col_o <= dct_pkg::SHIFT_COL_RST;
        end else if (reg_we_i) begin
            if (reg_addr_i == dct_pkg::REG_SHIFT_ROW) begin
                shift_row_o <= reg_wdata_i[3:0];
            end
            if (reg_addr_i == dct_pkg::REG_SHIFT_COL) begin
                shift_col_o <= reg_wdata_i[3:0];
            end
        end
    end

    // wrapping count of finished blocks, a write clears it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks <= 8'd0;
        end else if (reg_we_i && reg_addr_i == dct_pkg::REG_BLOCKS) begin
            blocks <= 8'd0;
        end else if (block_done_i) begin
            blocks <= blocks + 8'd1;
        end
    end

    always_comb begin
        case (reg_addr_i)
            dct_pkg::REG_SHIFT_ROW: reg_rdata_o = {4'd0, shift_row_o};
            dct_pkg::REG_SHIFT_COL: reg_rdata_o = {4'd0, shift_col_o};
            dct_pkg::REG_BLOCKS:    reg_rdata_o = blocks;
            default:                reg_rdata_o = 8'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== transpose/transpose_buf.sv ====
`default_nettype none

module transpose_buf #(
    parameter type sample_t = dct_pkg::row_t
) (
    input  wire logic           clk,
    input  wire logic           resetn,

    input  wire sample_t        d_i [dct_pkg::N_PT],
    input  wire dct_pkg::idx_t  d_cnt_i,
    input  wire logic           d_valid_i,
    output logic                d_hold_o,

    output sample_t             q_o [dct_pkg::N_PT],
    output dct_pkg::idx_t       q_cnt_o,
    output logic                q_valid_o,
    input  wire logic           q_hold_i
);

    // two banks, indexed [bank][row][column]
    sample_t mem [2][dct_pkg::N_PT][dct_pkg::N_PT];

    // bank pointers, bit 1 is the wrap bit
    logic [1:0]    wptr;
    logic [1:0]    rptr;
    logic          full;
    logic          empty;

    logic          wr_en;
    logic          rd_adv;
    logic          rd_en;
    dct_pkg::idx_t col_cnt;

    always_comb begin
        full  = (wptr[1] != rptr[1]) & (wptr[0] == rptr[0]);
        empty = (wptr == rptr);
    end

    always_comb begin
        d_hold_o = full;
        wr_en    = d_valid_i & ~full;
    end

    // write side, one row per beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= 2'd0;
        end else if (wr_en && d_cnt_i == 3'd7) begin
            wptr <= wptr + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int c = 0; c < dct_pkg::N_PT; c++) begin
                mem[wptr[0]][d_cnt_i][c] <= d_i[c];
            end
        end
    end

    // output reg takes a new column when empty or when its beat goes out
    always_comb begin
        rd_adv = ~q_valid_o | ~q_hold_i;
        rd_en  = rd_adv & ~empty;
    end

    // read side, one column per beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr    <= 2'd0;
            col_cnt <= 3'd0;
        end else if (rd_en) begin
            col_cnt <= col_cnt + 3'd1;
            // bank is free once column 7 sits in the output reg
            if (col_cnt == 3'd7) begin
                rptr <= rptr + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_valid_o <= 1'b0;
        end else if (rd_adv) begin
            q_valid_o <= ~empty;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int r = 0; r < dct_pkg::N_PT; r++) begin
                q_o[r] <= mem[rptr[0]][r][col_cnt];
            end
            q_cnt_o <= col_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dct2d_top.sv ====
`default_nettype none

module dct2d_top (
    input  wire logic            clk,
    input  wire logic            resetn,

    input  wire dct_pkg::pix_t   d_i [dct_pkg::N_PT],
    input  wire dct_pkg::idx_t   d_cnt_i,
    input  wire logic            d_valid_i,
    output logic                 d_hold_o,

    output dct_pkg::coef_t       q_o [dct_pkg::N_PT],
    output dct_pkg::idx_t        q_cnt_o,
    output logic                 q_valid_o,
    input  wire logic            q_hold_i,

    input  wire logic            reg_we_i,
    input  wire logic [1:0]      reg_addr_i,
    input  wire logic [7:0]      reg_wdata_i,
    output logic      [7:0]      reg_rdata_o
);

    // row pass to transpose A
    dct_pkg::row_t   row_q [dct_pkg::N_PT];
    dct_pkg::idx_t   row_cnt;
    logic            row_valid;
    logic            row_hold;

    // transpose A to column pass
    dct_pkg::row_t   ta_q [dct_pkg::N_PT];
    dct_pkg::idx_t   ta_cnt;
    logic            ta_valid;
    logic            ta_hold;

    // column pass to transpose B
    dct_pkg::coef_t  col_q [dct_pkg::N_PT];
    dct_pkg::idx_t   col_cnt;
    logic            col_valid;
    logic            col_hold;

    dct_pkg::shift_t shift_row;
    dct_pkg::shift_t shift_col;
    logic            block_done;

    // last row of a block leaving the core
    assign block_done = q_valid_o & ~q_hold_i & (q_cnt_o == 3'd7);

    dct_1d #(
        .in_t  (dct_pkg::pix_t),
        .out_t (dct_pkg::row_t)
    ) i_row_dct (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (d_i),
        .d_cnt_i   (d_cnt_i),
        .d_valid_i (d_valid_i),
        .d_hold_o  (d_hold_o),
        .shift_i   (shift_row),
        .q_o       (row_q),
        .q_cnt_o   (row_cnt),
        .q_valid_o (row_valid),
        .q_hold_i  (row_hold)
    );

    transpose_buf #(
        .sample_t (dct_pkg::row_t)
    ) i_trans_a (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (row_q),
        .d_cnt_i   (row_cnt),
        .d_valid_i (row_valid),
        .d_hold_o  (row_hold),
        .q_o       (ta_q),
        .q_cnt_o   (ta_cnt),
        .q_valid_o (ta_valid),
        .q_hold_i  (ta_hold)
    );

    dct_1d #(
        .in_t  (dct_pkg::row_t),
        .out_t (dct_pkg::coef_t)
    ) i_col_dct (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (ta_q),
        .d_cnt_i   (ta_cnt),
        .d_valid_i (ta_valid),
        .d_hold_o  (ta_hold),
        .shift_i   (shift_col),
        .q_o       (col_q),
        .q_cnt_o   (col_cnt),
        .q_valid_o (col_valid),
        .q_hold_i  (col_hold)
    );

    transpose_buf #(
        .sample_t (dct_pkg::coef_t)
    ) i_trans_b (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (col_q),
        .d_cnt_i   (col_cnt),
        .d_valid_i (col_valid),
        .d_hold_o  (col_hold),
        .q_o       (q_o),
        .q_cnt_o   (q_cnt_o),
        .q_valid_o (q_valid_o),
        .q_hold_i  (q_hold_i)
    );

    dct_cfg_regs i_cfg (
        .clk          (clk),
        .resetn       (resetn),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .block_done_i (block_done),
        .shift_row_o  (shift_row),
        .shift_col_o  (shift_col)
    );

endmodule

`default_nettype wire

// ==== testbench/dct2d_chk.sv ====
`default_nettype none

module dct2d_chk (
    input wire logic           clk,
    input wire logic           resetn,
    input wire dct_pkg::coef_t q_o [dct_pkg::N_PT],
    input wire dct_pkg::idx_t  q_cnt_o,
    input wire logic           q_valid_o,
    input wire logic           q_hold_i
);

    localparam int W = $bits(dct_pkg::coef_t);

    logic [dct_pkg::N_PT*W-1:0] q_flat;
    dct_pkg::idx_t              last_cnt;
    logic                       seen;
    int                         fail_cnt = 0;

    always_comb begin
        for (int j = 0; j < dct_pkg::N_PT; j++) begin
            q_flat[j*W +: W] = q_o[j];
        end
    end

    // index of the previous accepted beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            seen <= 1'b0;
        end else if (q_valid_o && !q_hold_i) begin
            seen     <= 1'b1;
            last_cnt <= q_cnt_o;
        end
    end

    stall_stable: assert property (@(posedge clk) disable iff (!resetn)
        q_valid_o && q_hold_i |=> q_valid_o && $stable(q_flat) && $stable(q_cnt_o))
        else begin
            fail_cnt++;
            $error("output row changed while stalled");
        end

    reset_clears: assert property (@(posedge clk) !resetn |=> !q_valid_o)
        else begin
            fail_cnt++;
            $error("output valid high after reset");
        end

    count_step: assert property (@(posedge clk) disable iff (!resetn)
        q_valid_o && !q_hold_i && seen |-> q_cnt_o == dct_pkg::idx_t'(last_cnt + 3'd1))
        else begin
            fail_cnt++;
            $error("output row index skipped or repeated");
        end

endmodule

bind dct2d_top dct2d_chk i_chk (.*);

`default_nettype wire

// ==== testbench/dct2d_tb.sv ====
`default_nettype none

module dct2d_tb;

    localparam int PERIOD    = 40;
    localparam int NB_MAX    = 6;
    localparam int N_BLOCKS  = 17;
    localparam int WD_CYCLES = N_BLOCKS * 200 + 500;
    localparam int ROW_W     = $bits(dct_pkg::row_t);
    localparam int COEF_W    = $bits(dct_pkg::coef_t);

    logic clk = 1'b0;
    logic resetn;
    dct_pkg::pix_t  d_i [dct_pkg::N_PT];
    dct_pkg::idx_t  d_cnt_i;
    logic           d_valid_i;
    logic           d_hold_o;
    dct_pkg::coef_t q_o [dct_pkg::N_PT];
    dct_pkg::idx_t  q_cnt_o;
    logic           q_valid_o;
    logic           q_hold_i;
    logic           reg_we_i;
    logic [1:0]     reg_addr_i;
    logic [7:0]     reg_wdata_i;
    logic [7:0]     reg_rdata_o;

    logic [31:0]     lfsr = 32'h61a4411a;
    logic            hold_rand = 1'b0;
    int              mism_errs = 0;
    int              other_errs = 0;
    dct_pkg::shift_t shift_r = dct_pkg::SHIFT_ROW_RST;
    dct_pkg::shift_t shift_c = dct_pkg::SHIFT_COL_RST;
    dct_pkg::pix_t   stim [NB_MAX * 64];
    longint          ymod [dct_pkg::N_PT][dct_pkg::N_PT];
    dct_pkg::coef_t  want_coef [$];
    dct_pkg::idx_t   want_idx [$];
    dct_pkg::coef_t  want_row [dct_pkg::N_PT];

    dct2d_top i_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // add half an LSB, shift, clamp to a w-bit signed range
    function automatic longint round_sat(input longint acc, input int sh, input int w);
        longint v;
        longint lim;
        v = (acc + ((longint'(1) << sh) >>> 1)) >>> sh;
        lim = (longint'(1) << (w - 1)) - 1;
        if (v > lim) begin
            return lim;
        end
        if (v < -lim - 1) begin
            return -lim - 1;
        end
        return v;
    endfunction

    task automatic check_coef_row(input dct_pkg::idx_t got_idx, input dct_pkg::idx_t exp_idx,
                                  input dct_pkg::coef_t got [dct_pkg::N_PT],
                                  input dct_pkg::coef_t exp [dct_pkg::N_PT]);
        if (got_idx !== exp_idx) begin
            $display("MISMATCH at %0t: row index %0d, expected %0d", $time, got_idx, exp_idx);
            mism_errs++;
        end
        for (int j = 0; j < dct_pkg::N_PT; j++) begin
            if (got[j] !== exp[j]) begin
                $display("MISMATCH at %0t: Y[%0d][%0d] is %0d, expected %0d",
                         $time, exp_idx, j, got[j], exp[j]);
                mism_errs++;
            end
        end
    endtask

    task automatic check_reg(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s reads %0d, expected %0d", $time, what, got, exp);
            mism_errs++;
        end
    endtask

    // reference model of one block from stim, rows queued as they should leave
    task automatic queue_block(input int b);
        longint rm [dct_pkg::N_PT][dct_pkg::N_PT];
        longint acc;
        for (int r = 0; r < dct_pkg::N_PT; r++) begin
            for (int k = 0; k < dct_pkg::N_PT; k++) begin
                acc = 0;
                for (int n = 0; n < dct_pkg::N_PT; n++) begin
                    acc += dct_pkg::DCT_COS[k][n] * stim[b * 64 + r * 8 + n];
                end
                rm[r][k] = round_sat(acc, shift_r, ROW_W);
            end
        end
        for (int k = 0; k < dct_pkg::N_PT; k++) begin
            want_idx.push_back(dct_pkg::idx_t'(k));
            for (int j = 0; j < dct_pkg::N_PT; j++) begin
                acc = 0;
                for (int n = 0; n < dct_pkg::N_PT; n++) begin
                    acc += dct_pkg::DCT_COS[k][n] * rm[n][j];
                end
                ymod[k][j] = round_sat(acc, shift_c, COEF_W);
                want_coef.push_back(dct_pkg::coef_t'(ymod[k][j]));
            end
        end
    endtask

    task automatic gen_random(input int nb);
        for (int i = 0; i < nb * 64; i++) begin
            stim[i] = dct_pkg::pix_t'(rand_bits(9));
        end
        for (int b = 0; b < nb; b++) begin
            queue_block(b);
        end
    endtask

    // caller sits on a rising edge
    task automatic send_blocks(input int nb);
        for (int b = 0; b < nb; b++) begin
            for (int r = 0; r < dct_pkg::N_PT; r++) begin
                for (int n = 0; n < dct_pkg::N_PT; n++) begin
                    d_i[n] <= stim[b * 64 + r * 8 + n];
                end
                d_cnt_i   <= dct_pkg::idx_t'(r);
                d_valid_i <= 1'b1;
                @(posedge clk);
                while (d_hold_o) begin
                    @(posedge clk);
                end
            end
        end
        d_valid_i <= 1'b0;
    endtask

    task automatic wait_drain(input int max_cyc);
        int n;
        n = 0;
        while (want_idx.size() != 0 && n < max_cyc) begin
            @(posedge clk);
            n++;
        end
        if (want_idx.size() != 0) begin
            $display("%0d coefficient rows never left the core by %0t", want_idx.size(), $time);
            other_errs++;
            want_idx.delete();
            want_coef.delete();
        end
        @(posedge clk);
    endtask

    task automatic reg_write(input logic [1:0] a, input logic [7:0] v);
        reg_we_i    <= 1'b1;
        reg_addr_i  <= a;
        reg_wdata_i <= v;
        @(posedge clk);
        reg_we_i <= 1'b0;
        if (a == dct_pkg::REG_SHIFT_ROW) begin
            shift_r = v[3:0];
        end else if (a == dct_pkg::REG_SHIFT_COL) begin
            shift_c = v[3:0];
        end
    endtask

    task automatic reg_expect(input logic [1:0] a, input logic [7:0] v, input string what);
        reg_addr_i <= a;
        @(posedge clk);
        check_reg(what, reg_rdata_o, v);
    endtask

    task automatic test_regs();
        if (d_hold_o !== 1'b0 || q_valid_o !== 1'b0) begin
            $display("hold or output valid not low after reset");
            other_errs++;
        end
        reg_expect(dct_pkg::REG_SHIFT_ROW, 8'd5, "row shift after reset");
        reg_expect(dct_pkg::REG_SHIFT_COL, 8'd8, "column shift after reset");
        reg_expect(dct_pkg::REG_BLOCKS, 8'd0, "block count after reset");
        reg_expect(2'd3, 8'd0, "unused address");
        reg_write(dct_pkg::REG_SHIFT_ROW, 8'd3);
        reg_write(dct_pkg::REG_SHIFT_COL, 8'd11);
        reg_expect(dct_pkg::REG_SHIFT_ROW, 8'd3, "written row shift");
        reg_expect(dct_pkg::REG_SHIFT_COL, 8'd11, "written column shift");
        reg_write(dct_pkg::REG_SHIFT_ROW, 8'd5);
        reg_write(dct_pkg::REG_SHIFT_COL, 8'd8);
    endtask

    task automatic test_constant();
        int nz;
        nz = 0;
        for (int i = 0; i < 64; i++) begin
            stim[i] = 9'sd100;
        end
        queue_block(0);
        for (int k = 0; k < 64; k++) begin
            nz += (ymod[k / 8][k % 8] != 0) ? 1 : 0;
        end
        if (nz != 1 || ymod[0][0] == 0) begin
            $display("constant block model has %0d nonzero coefficients", nz);
            other_errs++;
        end
        send_blocks(1);
        wait_drain(400);
    endtask

    task automatic test_stream(input logic use_hold);
        reg_write(dct_pkg::REG_BLOCKS, 8'd0);
        gen_random(NB_MAX);
        hold_rand = use_hold;
        send_blocks(NB_MAX);
        wait_drain(NB_MAX * 200);
        hold_rand = 1'b0;
        reg_expect(dct_pkg::REG_BLOCKS, 8'(NB_MAX), "block count after stream");
    endtask

    task automatic test_saturate();
        reg_write(dct_pkg::REG_SHIFT_ROW, 8'd0);
        reg_write(dct_pkg::REG_SHIFT_COL, 8'd0);
        for (int i = 0; i < 64; i++) begin
            stim[i]      = ((i % 8 + i / 8) % 2 == 1) ? -9'sd255 : 9'sd255;
            stim[64 + i] = ((i % 8 < 4) ^ (i / 8 % 2 == 1)) ? 9'sd255 : -9'sd255;
        end
        queue_block(0);
        queue_block(1);
        send_blocks(2);
        wait_drain(400);
    endtask

    task automatic test_shift_change();
        reg_write(dct_pkg::REG_BLOCKS, 8'd0);
        reg_write(dct_pkg::REG_SHIFT_ROW, 8'd3);
        reg_write(dct_pkg::REG_SHIFT_COL, 8'd6);
        gen_random(1);
        send_blocks(1);
        wait_drain(300);
        reg_write(dct_pkg::REG_SHIFT_ROW, 8'd7);
        reg_write(dct_pkg::REG_SHIFT_COL, 8'd10);
        gen_random(1);
        send_blocks(1);
        wait_drain(300);
        reg_expect(dct_pkg::REG_BLOCKS, 8'd2, "block count after two blocks");
        reg_write(dct_pkg::REG_BLOCKS, 8'd0);
        reg_expect(dct_pkg::REG_BLOCKS, 8'd0, "block count after clear");
    endtask

    always @(posedge clk) begin
        if (hold_rand) begin
            q_hold_i <= lfsr_bit();
        end else begin
            q_hold_i <= 1'b0;
        end
    end

    // each accepted output row is compared with the oldest queued row
    always @(posedge clk) begin
        if (resetn && q_valid_o && !q_hold_i) begin
            if (want_idx.size() == 0) begin
                $display("unexpected output row %0d at %0t", q_cnt_o, $time);
                other_errs++;
            end else begin
                for (int j = 0; j < dct_pkg::N_PT; j++) begin
                    want_row[j] = want_coef.pop_front();
                end
                check_coef_row(q_cnt_o, want_idx.pop_front(), q_o, want_row);
            end
        end
    end

    initial begin
        #(WD_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        resetn      = 1'b0;
        d_cnt_i     = '0;
        d_valid_i   = 1'b0;
        q_hold_i    = 1'b0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        for (int n = 0; n < dct_pkg::N_PT; n++) begin
            d_i[n] = '0;
        end
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        test_regs();
        test_constant();
        test_stream(1'b0);
        test_stream(1'b1);
        test_saturate();
        test_shift_change();
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mism_errs, other_errs, i_dut.i_chk.fail_cnt);
        if (mism_errs + other_errs + i_dut.i_chk.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/dct_pkg.sv
verilog/dct_1d.sv
verilog/dct_cfg_regs.sv
transpose/transpose_buf.sv
verilog/dct2d_top.sv
testbench/dct2d_chk.sv
testbench/dct2d_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the 2-D DCT testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dct2d_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdct2d_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
